//--- verilog/frv_core_decode.svh
// Instruction match terms, one flag per supported RV32IMC instruction
`ifndef FRV_CORE_DECODE_SVH
`define FRV_CORE_DECODE_SVH

// Encoding fields
wire [6:0] enc_opc = d_data[6:0];
wire [2:0] enc_f3  = d_data[14:12];
wire [6:0] enc_f7  = d_data[31:25];
wire [2:0] enc_cf3 = d_data[15:13];    // Compressed funct3

wire enc_op  = enc_opc == 7'b0110011;
wire enc_opi = enc_opc == 7'b0010011;
wire enc_ld  = enc_opc == 7'b0000011;
wire enc_st  = enc_opc == 7'b0100011;
wire enc_br  = enc_opc == 7'b1100011;
wire enc_f7z = enc_f7 == 7'b0000000;
wire enc_f7a = enc_f7 == 7'b0100000;   // sub / sra / srai
wire enc_f7m = enc_f7 == 7'b0000001;   // M extension
wire enc_q0  = d_data[1:0] == 2'b00;
wire enc_q1  = d_data[1:0] == 2'b01;
wire enc_q2  = d_data[1:0] == 2'b10;

// -----------------------------------------------------------------------
// RV32I
// -----------------------------------------------------------------------

wire dec_lui   = enc_opc == 7'b0110111;
wire dec_auipc = enc_opc == 7'b0010111;
wire dec_jal   = enc_opc == 7'b1101111;
wire dec_jalr  = enc_opc == 7'b1100111 && enc_f3 == 3'b000;
wire dec_beq   = enc_br && enc_f3 == 3'b000;
wire dec_bne   = enc_br && enc_f3 == 3'b001;
wire dec_blt   = enc_br && enc_f3 == 3'b100;
wire dec_bge   = enc_br && enc_f3 == 3'b101;
wire dec_bltu  = enc_br && enc_f3 == 3'b110;
wire dec_bgeu  = enc_br && enc_f3 == 3'b111;
wire dec_lb    = enc_ld && enc_f3 == 3'b000;
wire dec_lh    = enc_ld && enc_f3 == 3'b001;
wire dec_lw    = enc_ld && enc_f3 == 3'b010;
wire dec_lbu   = enc_ld && enc_f3 == 3'b100;
wire dec_lhu   = enc_ld && enc_f3 == 3'b101;
wire dec_sb    = enc_st && enc_f3 == 3'b000;
wire dec_sh    = enc_st && enc_f3 == 3'b001;
wire dec_sw    = enc_st && enc_f3 == 3'b010;
wire dec_addi  = enc_opi && enc_f3 == 3'b000;
wire dec_slti  = enc_opi && enc_f3 == 3'b010;
wire dec_sltiu = enc_opi && enc_f3 == 3'b011;
wire dec_xori  = enc_opi && enc_f3 == 3'b100;
wire dec_ori   = enc_opi && enc_f3 == 3'b110;
wire dec_andi  = enc_opi && enc_f3 == 3'b111;
wire dec_slli  = enc_opi && enc_f3 == 3'b001 && enc_f7z;
wire dec_srli  = enc_opi && enc_f3 == 3'b101 && enc_f7z;
wire dec_srai  = enc_opi && enc_f3 == 3'b101 && enc_f7a;
wire dec_add   = enc_op && enc_f3 == 3'b000 && enc_f7z;
wire dec_sub   = enc_op && enc_f3 == 3'b000 && enc_f7a;
wire dec_sll   = enc_op && enc_f3 == 3'b001 && enc_f7z;
wire dec_slt   = enc_op && enc_f3 == 3'b010 && enc_f7z;
wire dec_sltu  = enc_op && enc_f3 == 3'b011 && enc_f7z;
wire dec_xor   = enc_op && enc_f3 == 3'b100 && enc_f7z;
wire dec_srl   = enc_op && enc_f3 == 3'b101 && enc_f7z;
wire dec_sra   = enc_op && enc_f3 == 3'b101 && enc_f7a;
wire dec_or    = enc_op && enc_f3 == 3'b110 && enc_f7z;
wire dec_and   = enc_op && enc_f3 == 3'b111 && enc_f7z;

// RV32M
wire dec_mul    = enc_op && enc_f7m && enc_f3 == 3'b000;
wire dec_mulh   = enc_op && enc_f7m && enc_f3 == 3'b001;
wire dec_mulhsu = enc_op && enc_f7m && enc_f3 == 3'b010;
wire dec_mulhu  = enc_op && enc_f7m && enc_f3 == 3'b011;
wire dec_div    = enc_op && enc_f7m && enc_f3 == 3'b100;
wire dec_divu   = enc_op && enc_f7m && enc_f3 == 3'b101;
wire dec_rem    = enc_op && enc_f7m && enc_f3 == 3'b110;
wire dec_remu   = enc_op && enc_f7m && enc_f3 == 3'b111;

// Compressed subset
wire dec_c_addi = enc_q1 && enc_cf3 == 3'b000 && d_data[11:7] != 5'd0; // rd 0 is c.nop
wire dec_c_li   = enc_q1 && enc_cf3 == 3'b010;
wire dec_c_j    = enc_q1 && enc_cf3 == 3'b101;
wire dec_c_beqz = enc_q1 && enc_cf3 == 3'b110;
wire dec_c_lw   = enc_q0 && enc_cf3 == 3'b010;
wire dec_c_sw   = enc_q0 && enc_cf3 == 3'b110;
wire dec_c_mv   = enc_q2 && enc_cf3 == 3'b100 && !d_data[12] && d_data[6:2] != 5'd0;
wire dec_c_add  = enc_q2 && enc_cf3 == 3'b100 && d_data[12] && d_data[6:2] != 5'd0;

`endif

//--- verilog/frv_pkg.sv
// Shared widths, functional units, micro-op codes and trap causes for the decode stage
package frv_pkg;

    // -------------------------------------------------------------------
    // Width types
    // -------------------------------------------------------------------

    typedef logic [31:0] word_t;       // Instruction, immediate or PC
    typedef logic [4:0]  reg_addr_t;
    typedef logic [4:0]  uop_t;
    typedef logic [4:0]  fu_t;         // One-hot functional unit
    typedef logic [1:0]  size_t;       // Bit 0 for 16-bit, bit 1 for 32-bit
    typedef logic [5:0]  trap_cause_t;

    // Functional unit bit positions
    localparam int FU_ALU = 0;
    localparam int FU_MUL = 1;
    localparam int FU_CFU = 2;
    localparam int FU_LSU = 3;
    localparam int FU_CSR = 4;         // Never set by this decoder

    // -------------------------------------------------------------------
    // Micro-op codes
    // -------------------------------------------------------------------

    localparam uop_t ALU_ADD  = 5'd1;
    localparam uop_t ALU_SUB  = 5'd2;
    localparam uop_t ALU_AND  = 5'd3;
    localparam uop_t ALU_OR   = 5'd4;
    localparam uop_t ALU_XOR  = 5'd5;
    localparam uop_t ALU_SLT  = 5'd6;
    localparam uop_t ALU_SLTU = 5'd7;
    localparam uop_t ALU_SRA  = 5'd8;
    localparam uop_t ALU_SRL  = 5'd9;
    localparam uop_t ALU_SLL  = 5'd10;

    localparam uop_t CFU_BEQ  = 5'd1;
    localparam uop_t CFU_BNE  = 5'd2;
    localparam uop_t CFU_BLT  = 5'd3;
    localparam uop_t CFU_BGE  = 5'd4;
    localparam uop_t CFU_BLTU = 5'd5;
    localparam uop_t CFU_BGEU = 5'd6;
    localparam uop_t CFU_JALI = 5'd7;  // Jump to PC relative target
    localparam uop_t CFU_JALR = 5'd8;  // Jump to register target

    localparam uop_t MUL_MUL    = 5'd1;
    localparam uop_t MUL_MULH   = 5'd2;
    localparam uop_t MUL_MULHSU = 5'd3;
    localparam uop_t MUL_MULHU  = 5'd4;
    localparam uop_t MUL_DIV    = 5'd5;
    localparam uop_t MUL_DIVU   = 5'd6;
    localparam uop_t MUL_REM    = 5'd7;
    localparam uop_t MUL_REMU   = 5'd8;

    // Load/store uop is a bit field, width code sits in bits 2:1
    localparam int LSU_LOAD   = 0;
    localparam int LSU_STORE  = 3;
    localparam int LSU_SIGNED = 4;
    localparam logic [1:0] LSU_BYTE = 2'b01;
    localparam logic [1:0] LSU_HALF = 2'b10;
    localparam logic [1:0] LSU_WORD = 2'b11;

    // Trap causes, carried on the destination address
    localparam trap_cause_t TRAP_IACCESS = 6'd1;
    localparam trap_cause_t TRAP_IOPCODE = 6'd2;

    // Fixed registers
    localparam reg_addr_t REG_ZERO = 5'd0;
    localparam reg_addr_t REG_RA   = 5'd1;
    localparam reg_addr_t REG_SP   = 5'd2;

endpackage

//--- verilog/frv_core_decode.sv
// Combinational RV32IMC decoder producing the wide pipeline encoding
`timescale 1ns/1ps

module frv_core_decode (
    input  frv_pkg::word_t     d_data,
    input  logic               d_error,   // Fetch error on this word
    input  logic               ext_m_en,
    input  logic               ext_c_en,
    output frv_pkg::reg_addr_t dec_rd,
    output frv_pkg::reg_addr_t dec_rs1,
    output frv_pkg::reg_addr_t dec_rs2,
    output frv_pkg::word_t     dec_imm,
    output frv_pkg::uop_t      dec_uop,
    output frv_pkg::fu_t       dec_fu,
    output logic               dec_trap,
    output frv_pkg::size_t     dec_size,
    output frv_pkg::word_t     dec_instr
);

`include "frv_core_decode.svh"

    wire instr_16bit = d_data[1:0] != 2'b11;

    // -------------------------------------------------------------------
    // Functional unit
    // -------------------------------------------------------------------

    frv_pkg::fu_t fu_raw;

    assign fu_raw[frv_pkg::FU_ALU] =
        dec_add  || dec_addi  || dec_c_add || dec_c_addi || dec_c_mv   || dec_auipc ||
        dec_sub  || dec_and   || dec_andi  || dec_lui    || dec_c_li   || dec_or    ||
        dec_ori  || dec_xor   || dec_xori  || dec_slt    || dec_slti   || dec_sltu  ||
        dec_sltiu || dec_sra  || dec_srai  || dec_srl    || dec_srli   || dec_sll   ||
        dec_slli;
    assign fu_raw[frv_pkg::FU_MUL] =
        dec_mul  || dec_mulh  || dec_mulhsu || dec_mulhu || dec_div    || dec_divu  ||
        dec_rem  || dec_remu;
    assign fu_raw[frv_pkg::FU_CFU] =
        dec_beq  || dec_bne   || dec_blt   || dec_bge    || dec_bltu   || dec_bgeu  ||
        dec_c_beqz || dec_jal || dec_jalr  || dec_c_j;
    assign fu_raw[frv_pkg::FU_LSU] =
        dec_lb   || dec_lbu   || dec_lh    || dec_lhu    || dec_lw     || dec_sb    ||
        dec_sh   || dec_sw    || dec_c_lw  || dec_c_sw;
    assign fu_raw[frv_pkg::FU_CSR] = 1'b0;

    // Disabled extensions decode as illegal
    wire invalid_instr = fu_raw == '0 ||
                         (fu_raw[frv_pkg::FU_MUL] && !ext_m_en) ||
                         (instr_16bit && !ext_c_en);

    wire frv_pkg::trap_cause_t trap_cause =
        invalid_instr ? frv_pkg::TRAP_IOPCODE : frv_pkg::TRAP_IACCESS;

    assign dec_trap = d_error || invalid_instr;
    assign dec_fu   = dec_trap ? '0 : fu_raw;

    // -------------------------------------------------------------------
    // Micro-op
    // -------------------------------------------------------------------

    wire frv_pkg::uop_t uop_alu =
        {5{dec_add  || dec_addi || dec_c_add || dec_c_addi || dec_c_mv || dec_auipc}}
                                                  & frv_pkg::ALU_ADD  |
        {5{dec_sub                              }} & frv_pkg::ALU_SUB  |
        {5{dec_and  || dec_andi                 }} & frv_pkg::ALU_AND  |
        {5{dec_lui  || dec_c_li || dec_or || dec_ori}} & frv_pkg::ALU_OR |
        {5{dec_xor  || dec_xori                 }} & frv_pkg::ALU_XOR  |
        {5{dec_slt  || dec_slti                 }} & frv_pkg::ALU_SLT  |
        {5{dec_sltu || dec_sltiu                }} & frv_pkg::ALU_SLTU |
        {5{dec_sra  || dec_srai                 }} & frv_pkg::ALU_SRA  |
        {5{dec_srl  || dec_srli                 }} & frv_pkg::ALU_SRL  |
        {5{dec_sll  || dec_slli                 }} & frv_pkg::ALU_SLL;

    wire frv_pkg::uop_t uop_cfu =
        {5{dec_beq || dec_c_beqz}} & frv_pkg::CFU_BEQ  |
        {5{dec_bne              }} & frv_pkg::CFU_BNE  |
        {5{dec_blt              }} & frv_pkg::CFU_BLT  |
        {5{dec_bge              }} & frv_pkg::CFU_BGE  |
        {5{dec_bltu             }} & frv_pkg::CFU_BLTU |
        {5{dec_bgeu             }} & frv_pkg::CFU_BGEU |
        {5{dec_jal  || dec_c_j  }} & frv_pkg::CFU_JALI |
        {5{dec_jalr             }} & frv_pkg::CFU_JALR;

    wire frv_pkg::uop_t uop_mul =
        {5{dec_mul   }} & frv_pkg::MUL_MUL    |
        {5{dec_mulh  }} & frv_pkg::MUL_MULH   |
        {5{dec_mulhsu}} & frv_pkg::MUL_MULHSU |
        {5{dec_mulhu }} & frv_pkg::MUL_MULHU  |
        {5{dec_div   }} & frv_pkg::MUL_DIV    |
        {5{dec_divu  }} & frv_pkg::MUL_DIVU   |
        {5{dec_rem   }} & frv_pkg::MUL_REM    |
        {5{dec_remu  }} & frv_pkg::MUL_REMU;

    frv_pkg::uop_t uop_lsu;

    assign uop_lsu[2:1] =
        {2{dec_lb || dec_lbu || dec_sb}} & frv_pkg::LSU_BYTE |
        {2{dec_lh || dec_lhu || dec_sh}} & frv_pkg::LSU_HALF |
        {2{dec_lw || dec_sw  || dec_c_lw || dec_c_sw}} & frv_pkg::LSU_WORD;
    assign uop_lsu[frv_pkg::LSU_LOAD]   = dec_lb || dec_lbu || dec_lh || dec_lhu || dec_lw ||
                                          dec_c_lw;
    assign uop_lsu[frv_pkg::LSU_STORE]  = dec_sb || dec_sh || dec_sw || dec_c_sw;
    assign uop_lsu[frv_pkg::LSU_SIGNED] = dec_lb || dec_lh;

    assign dec_uop = dec_trap ? '0 : (uop_alu | uop_cfu | uop_mul | uop_lsu);

    // -------------------------------------------------------------------
    // Registers, size and instruction word
    // -------------------------------------------------------------------

    wire frv_pkg::reg_addr_t rd_16 =
        {5{dec_c_addi || dec_c_li || dec_c_mv || dec_c_add}} & d_data[11:7] |
        {5{dec_c_lw                }} & {2'b01, d_data[4:2]}   |
        {5{dec_c_j                 }} & frv_pkg::REG_ZERO;       // c.j does not link

    wire frv_pkg::reg_addr_t rs1_16 =
        {5{dec_c_addi || dec_c_add }} & d_data[11:7]           |
        {5{dec_c_lw || dec_c_sw || dec_c_beqz}} & {2'b01, d_data[9:7]};

    wire frv_pkg::reg_addr_t rs2_16 =
        {5{dec_c_beqz              }} & frv_pkg::REG_ZERO      |
        {5{dec_c_add || dec_c_mv   }} & d_data[6:2]            |
        {5{dec_c_sw                }} & {2'b01, d_data[4:2]};

    assign dec_rs1   = instr_16bit ? rs1_16 : d_data[19:15];
    assign dec_rs2   = instr_16bit ? rs2_16 : d_data[24:20];
    assign dec_rd    = dec_trap    ? trap_cause[4:0] :
                       instr_16bit ? rd_16           : d_data[11:7];
    assign dec_size  = {!instr_16bit, instr_16bit};
    assign dec_instr = instr_16bit ? {16'b0, d_data[15:0]} : d_data;

    // -------------------------------------------------------------------
    // Immediates
    // -------------------------------------------------------------------

    wire frv_pkg::word_t imm_i = {{20{d_data[31]}}, d_data[31:20]};
    wire frv_pkg::word_t imm_s = {{20{d_data[31]}}, d_data[31:25], d_data[11:7]};
    wire frv_pkg::word_t imm_b = {{19{d_data[31]}}, d_data[31], d_data[7], d_data[30:25],
                                  d_data[11:8], 1'b0};
    wire frv_pkg::word_t imm_u = {d_data[31:12], 12'b0};
    wire frv_pkg::word_t imm_j = {{11{d_data[31]}}, d_data[31], d_data[19:12], d_data[20],
                                  d_data[30:21], 1'b0};
    wire frv_pkg::word_t imm_c_addi = {{27{d_data[12]}}, d_data[6:2]};
    wire frv_pkg::word_t imm_c_lsw  = {25'b0, d_data[5], d_data[12:10], d_data[6], 2'b00};
    wire frv_pkg::word_t imm_c_j    = {{21{d_data[12]}}, d_data[8], d_data[10:9], d_data[6],
                                       d_data[7], d_data[2], d_data[11], d_data[5:3], 1'b0};
    wire frv_pkg::word_t imm_c_bz   = {{24{d_data[12]}}, d_data[6:5], d_data[2],
                                       d_data[11:10], d_data[4:3], 1'b0};

    wire use_imm_i = dec_addi || dec_slti || dec_sltiu || dec_xori || dec_ori || dec_andi ||
                     dec_jalr || dec_lb   || dec_lbu   || dec_lh   || dec_lhu || dec_lw;
    wire use_shamt = dec_slli || dec_srli || dec_srai;   // Drop funct7 from the shift amount

    assign dec_imm =
        {32{use_imm_i              }} & imm_i      |
        {32{dec_sb || dec_sh || dec_sw}} & imm_s   |
        {32{fu_raw[frv_pkg::FU_CFU] && !instr_16bit && !dec_jal && !dec_jalr}} & imm_b |
        {32{dec_lui || dec_auipc   }} & imm_u      |
        {32{dec_jal                }} & imm_j      |
        {32{use_shamt              }} & {27'b0, d_data[24:20]} |
        {32{dec_c_addi || dec_c_li }} & imm_c_addi |
        {32{dec_c_lw || dec_c_sw   }} & imm_c_lsw  |
        {32{dec_c_j                }} & imm_c_j    |
        {32{dec_c_beqz             }} & imm_c_bz;

    // Unit terms above must stay mutually exclusive
    always_comb begin
        assert ($onehot0(dec_fu)) else $error("dec_fu has more than one unit set");
    end

endmodule

//--- verilog/frv_decode_cfg.sv
// Extension enable register steering the decoder, with write strobe and read-back
`timescale 1ns/1ps

module frv_decode_cfg (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cfg_we,
    input  logic [1:0] cfg_wdata,
    output logic [1:0] cfg_rdata,
    output logic       ext_m_en,
    output logic       ext_c_en
);

    // Both extensions come up enabled
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ext_m_en <= 1'b1;
            ext_c_en <= 1'b1;
        end else if (cfg_we) begin
            ext_m_en <= cfg_wdata[0];
            ext_c_en <= cfg_wdata[1];
        end
    end

    assign cfg_rdata = {ext_c_en, ext_m_en};   // Same layout as the write

endmodule

//--- verilog/frv_pipe_decode.sv
// Decode pipeline register with PC tracking, flush and stall
`timescale 1ns/1ps

module frv_pipe_decode #(
    parameter frv_pkg::word_t pc_reset_value = 32'h8000_0000
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               d_valid,
    input  logic               flush,
    input  frv_pkg::word_t     flush_pc,
    input  logic               s_stall,     // Downstream not ready
    input  frv_pkg::reg_addr_t dec_rd,
    input  frv_pkg::reg_addr_t dec_rs1,
    input  frv_pkg::reg_addr_t dec_rs2,
    input  frv_pkg::word_t     dec_imm,
    input  frv_pkg::uop_t      dec_uop,
    input  frv_pkg::fu_t       dec_fu,
    input  logic               dec_trap,
    input  frv_pkg::size_t     dec_size,
    input  frv_pkg::word_t     dec_instr,
    output logic               d_stall,
    output logic               p_valid,
    output frv_pkg::reg_addr_t p_rd,
    output frv_pkg::reg_addr_t p_rs1,
    output frv_pkg::reg_addr_t p_rs2,
    output frv_pkg::word_t     p_imm,
    output frv_pkg::word_t     p_pc,
    output frv_pkg::word_t     p_instr,
    output frv_pkg::uop_t      p_uop,
    output frv_pkg::fu_t       p_fu,
    output logic               p_trap,
    output frv_pkg::size_t     p_size
);

    frv_pkg::word_t pc_q;   // PC of the next instruction to accept

    assign d_stall = p_valid && s_stall;

    wire accept = d_valid && !d_stall && !flush;   // Flush drops a same-cycle instruction

    // -------------------------------------------------------------------
    // Control and PC
    // -------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            p_valid <= 1'b0;
            pc_q    <= pc_reset_value;
        end else if (flush) begin
            p_valid <= 1'b0;
            pc_q    <= flush_pc;
        end else if (accept) begin
            p_valid <= 1'b1;
            pc_q    <= pc_q + (dec_size[0] ? 32'd2 : 32'd4);
        end else if (!s_stall) begin
            p_valid <= 1'b0;           // Consumed downstream
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (accept) begin
            p_rd    <= dec_rd;
            p_rs1   <= dec_rs1;
            p_rs2   <= dec_rs2;
            p_imm   <= dec_imm;
            p_pc    <= pc_q;
            p_instr <= dec_instr;
            p_uop   <= dec_uop;
            p_fu    <= dec_fu;
            p_trap  <= dec_trap;
            p_size  <= dec_size;
        end
    end

    // -------------------------------------------------------------------
    // Checks
    // -------------------------------------------------------------------

    // Upstream must wait on d_stall
    assert property (@(posedge clk) disable iff (!rst_n) d_stall |-> !d_valid)
        else $error("d_valid raised while d_stall is high");

    // Only a flush may clear p_valid during a stall
    assert property (@(posedge clk) disable iff (!rst_n)
        d_stall && !flush |=> $stable({p_valid, p_rd, p_rs1, p_rs2, p_imm, p_pc, p_instr,
                                       p_uop, p_fu, p_trap, p_size}))
        else $error("Pipeline outputs changed during stall");

endmodule

//--- verilog/frv_decode_top.sv
// Decode stage top level joining configuration, decoder and pipeline register
`timescale 1ns/1ps

module frv_decode_top #(
    parameter frv_pkg::word_t pc_reset_value = 32'h8000_0000
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cfg_we,
    input  logic [1:0]         cfg_wdata,
    output logic [1:0]         cfg_rdata,
    input  logic               d_valid,
    input  frv_pkg::word_t     d_data,
    input  logic               d_error,
    input  logic               flush,
    input  frv_pkg::word_t     flush_pc,
    input  logic               s_stall,
    output logic               d_stall,
    output logic               p_valid,
    output frv_pkg::reg_addr_t p_rd,
    output frv_pkg::reg_addr_t p_rs1,
    output frv_pkg::reg_addr_t p_rs2,
    output frv_pkg::word_t     p_imm,
    output frv_pkg::word_t     p_pc,
    output frv_pkg::word_t     p_instr,
    output frv_pkg::uop_t      p_uop,
    output frv_pkg::fu_t       p_fu,
    output logic               p_trap,
    output frv_pkg::size_t     p_size
);

    logic               ext_m_en;
    logic               ext_c_en;
    frv_pkg::reg_addr_t dec_rd;
    frv_pkg::reg_addr_t dec_rs1;
    frv_pkg::reg_addr_t dec_rs2;
    frv_pkg::word_t     dec_imm;
    frv_pkg::uop_t      dec_uop;
    frv_pkg::fu_t       dec_fu;
    logic               dec_trap;
    frv_pkg::size_t     dec_size;
    frv_pkg::word_t     dec_instr;

    frv_decode_cfg i_frv_decode_cfg (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_we    (cfg_we),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .ext_m_en  (ext_m_en),
        .ext_c_en  (ext_c_en)
    );

    frv_core_decode i_frv_core_decode (
        .d_data    (d_data),
        .d_error   (d_error),
        .ext_m_en  (ext_m_en),
        .ext_c_en  (ext_c_en),
        .dec_rd    (dec_rd),
        .dec_rs1   (dec_rs1),
        .dec_rs2   (dec_rs2),
        .dec_imm   (dec_imm),
        .dec_uop   (dec_uop),
        .dec_fu    (dec_fu),
        .dec_trap  (dec_trap),
        .dec_size  (dec_size),
        .dec_instr (dec_instr)
    );

    frv_pipe_decode #(
        .pc_reset_value (pc_reset_value)
    ) i_frv_pipe_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .d_valid   (d_valid),
        .flush     (flush),
        .flush_pc  (flush_pc),
        .s_stall   (s_stall),
        .dec_rd    (dec_rd),
        .dec_rs1   (dec_rs1),
        .dec_rs2   (dec_rs2),
        .dec_imm   (dec_imm),
        .dec_uop   (dec_uop),
        .dec_fu    (dec_fu),
        .dec_trap  (dec_trap),
        .dec_size  (dec_size),
        .dec_instr (dec_instr),
        .d_stall   (d_stall),
        .p_valid   (p_valid),
        .p_rd      (p_rd),
        .p_rs1     (p_rs1),
        .p_rs2     (p_rs2),
        .p_imm     (p_imm),
        .p_pc      (p_pc),
        .p_instr   (p_instr),
        .p_uop     (p_uop),
        .p_fu      (p_fu),
        .p_trap    (p_trap),
        .p_size    (p_size)
    );

endmodule

//--- verif/tb_frv_decode_vectors.svh
// Decode test vectors, one row per instruction with its expected pipeline fields
`ifndef TB_FRV_DECODE_VECTORS_SVH
`define TB_FRV_DECODE_VECTORS_SVH

localparam int NUM_VEC = 23;

// Columns: instr, error, cfg, rd, rs1, rs2, imm, fu, uop, trap, size
// cfg bit 0 enables M and bit 1 enables C; size 01 is 16-bit, 10 is 32-bit
// fu 01 ALU, 02 MUL, 04 CFU, 08 LSU; on a trap rd holds the cause
localparam logic [94:0] VEC_TABLE [NUM_VEC] = '{
    // add x10, x10, x11
    {32'h00b50533, 1'b0, 2'b11, 5'd10, 5'd10, 5'd11, 32'h00000000, 5'h01, 5'd1, 1'b0, 2'b10},
    // c.addi x8, -1
    {32'h0000147d, 1'b0, 2'b11, 5'd8, 5'd8, 5'd0, 32'hffffffff, 5'h01, 5'd1, 1'b0, 2'b01},
    // addi x5, x6, -3
    {32'hffd30293, 1'b0, 2'b11, 5'd5, 5'd6, 5'd29, 32'hfffffffd, 5'h01, 5'd1, 1'b0, 2'b10},
    // c.li x9, 5
    {32'h00004495, 1'b0, 2'b11, 5'd9, 5'd0, 5'd0, 32'h00000005, 5'h01, 5'd4, 1'b0, 2'b01},
    // lw x7, 8(x2), load word
    {32'h00812383, 1'b0, 2'b11, 5'd7, 5'd2, 5'd8, 32'h00000008, 5'h08, 5'd7, 1'b0, 2'b10},
    // c.mv x10, x11
    {32'h0000852e, 1'b0, 2'b11, 5'd10, 5'd0, 5'd11, 32'h00000000, 5'h01, 5'd1, 1'b0, 2'b01},
    // sw x9, 12(x2), store word
    {32'h00912623, 1'b0, 2'b11, 5'd12, 5'd2, 5'd9, 32'h0000000c, 5'h08, 5'd14, 1'b0, 2'b10},
    // c.add x10, x11
    {32'h0000952e, 1'b0, 2'b11, 5'd10, 5'd10, 5'd11, 32'h00000000, 5'h01, 5'd1, 1'b0, 2'b01},
    // beq x1, x2, +16
    {32'h00208863, 1'b0, 2'b11, 5'd16, 5'd1, 5'd2, 32'h00000010, 5'h04, 5'd1, 1'b0, 2'b10},
    // c.lw x9, 4(x10)
    {32'h00004144, 1'b0, 2'b11, 5'd9, 5'd10, 5'd0, 32'h00000004, 5'h08, 5'd7, 1'b0, 2'b01},
    // jal x1, +8
    {32'h008000ef, 1'b0, 2'b11, 5'd1, 5'd0, 5'd8, 32'h00000008, 5'h04, 5'd7, 1'b0, 2'b10},
    // c.sw x11, 8(x12)
    {32'h0000c60c, 1'b0, 2'b11, 5'd0, 5'd12, 5'd11, 32'h00000008, 5'h08, 5'd14, 1'b0, 2'b01},
    // lui x3, 0x12345
    {32'h123451b7, 1'b0, 2'b11, 5'd3, 5'd8, 5'd3, 32'h12345000, 5'h01, 5'd4, 1'b0, 2'b10},
    // c.j +16, no link
    {32'h0000a801, 1'b0, 2'b11, 5'd0, 5'd0, 5'd0, 32'h00000010, 5'h04, 5'd7, 1'b0, 2'b01},
    // mul x12, x13, x14
    {32'h02e68633, 1'b0, 2'b11, 5'd12, 5'd13, 5'd14, 32'h00000000, 5'h02, 5'd1, 1'b0, 2'b10},
    // c.beqz x8, -4
    {32'h0000dc75, 1'b0, 2'b11, 5'd0, 5'd8, 5'd0, 32'hfffffffc, 5'h04, 5'd1, 1'b0, 2'b01},
    // Fetch error on add, access fault
    {32'h00b50533, 1'b1, 2'b11, 5'd1, 5'd10, 5'd11, 32'h00000000, 5'h00, 5'd0, 1'b1, 2'b10},
    // Unused opcode
    {32'h0000007f, 1'b0, 2'b11, 5'd2, 5'd0, 5'd0, 32'h00000000, 5'h00, 5'd0, 1'b1, 2'b10},
    // Unused opcode with fetch error, illegal wins
    {32'h0000007f, 1'b1, 2'b11, 5'd2, 5'd0, 5'd0, 32'h00000000, 5'h00, 5'd0, 1'b1, 2'b10},
    // mul with M disabled
    {32'h02e68633, 1'b0, 2'b10, 5'd2, 5'd13, 5'd14, 32'h00000000, 5'h00, 5'd0, 1'b1, 2'b10},
    // c.addi with C disabled
    {32'h0000147d, 1'b0, 2'b01, 5'd2, 5'd8, 5'd0, 32'hffffffff, 5'h00, 5'd0, 1'b1, 2'b01},
    // mul again after re-enable
    {32'h02e68633, 1'b0, 2'b11, 5'd12, 5'd13, 5'd14, 32'h00000000, 5'h02, 5'd1, 1'b0, 2'b10},
    // c.addi again after re-enable
    {32'h0000147d, 1'b0, 2'b11, 5'd8, 5'd8, 5'd0, 32'hffffffff, 5'h01, 5'd1, 1'b0, 2'b01}
};

`endif

//--- verif/tb_frv_decode.sv
// Table driven testbench for the decode stage with PC model, flush and stall checks
`timescale 1ns/1ps

module tb_frv_decode;

    localparam logic [31:0] PC_RESET = 32'h8000_0000;
    localparam logic [31:0] FLUSH_PC = 32'h0000_2000;
    localparam int          FLUSH_ROW = 8;     // Flush lands before this row

    logic clk = 1'b0;
    logic rst_n;
    logic cfg_we;
    logic [1:0] cfg_wdata;
    logic [1:0] cfg_rdata;
    logic d_valid;
    logic [31:0] d_data;
    logic d_error;
    logic flush;
    logic [31:0] flush_pc;
    logic s_stall;
    logic d_stall;
    logic p_valid;
    logic [4:0] p_rd, p_rs1, p_rs2, p_uop, p_fu;
    logic [31:0] p_imm, p_pc, p_instr;
    logic p_trap;
    logic [1:0] p_size;

    integer seed;
    int checks = 0;
    int errors = 0;
    int cycle_count = 0;
    logic [31:0] ref_pc;   // PC model

`include "tb_frv_decode_vectors.svh"

    localparam int MAX_CYCLES = NUM_VEC * 20 + 50;

    frv_decode_top #(
        .pc_reset_value (PC_RESET)
    ) i_frv_decode_top (
        .clk (clk), .rst_n (rst_n), .cfg_we (cfg_we), .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata), .d_valid (d_valid), .d_data (d_data), .d_error (d_error),
        .flush (flush), .flush_pc (flush_pc), .s_stall (s_stall), .d_stall (d_stall),
        .p_valid (p_valid), .p_rd (p_rd), .p_rs1 (p_rs1), .p_rs2 (p_rs2), .p_imm (p_imm),
        .p_pc (p_pc), .p_instr (p_instr), .p_uop (p_uop), .p_fu (p_fu), .p_trap (p_trap),
        .p_size (p_size)
    );

    always #2 clk = ~clk;

    // Run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the run did not complete", cycle_count);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // --------------------------------------------------------------------
    // One table row with config write, random gap, instruction and checks
    // --------------------------------------------------------------------

    task automatic apply_row(input int idx);
        logic [31:0] instr, exp_imm, exp_instr;
        logic [4:0]  exp_rd, exp_rs1, exp_rs2, exp_fu, exp_uop;
        logic [1:0]  cfg, exp_size;
        logic        err, exp_trap;
        int          gap, wait_cycles, err_before;
        {instr, err, cfg, exp_rd, exp_rs1, exp_rs2, exp_imm, exp_fu, exp_uop, exp_trap,
         exp_size} = VEC_TABLE[idx];
        err_before = errors;
        @(posedge clk);
        cfg_we    <= 1'b1;
        cfg_wdata <= cfg;
        @(posedge clk);
        cfg_we <= 1'b0;
        @(negedge clk);
        compare_field("cfg_rdata", 32'(cfg_rdata), 32'(cfg));
        gap = {$random(seed)} % 4;
        repeat (gap) @(posedge clk);
        @(posedge clk);
        d_valid <= 1'b1;
        d_data  <= instr;
        d_error <= err;
        @(posedge clk);
        d_valid <= 1'b0;
        @(negedge clk);
        wait_cycles = 0;
        while (!p_valid && wait_cycles < 8) begin
            @(negedge clk);
            wait_cycles++;
        end
        checks++;
        assert (p_valid) else begin
            $display("Row %0d: p_valid never rose after the instruction was sent", idx);
            errors++;
        end
        compare_field("p_valid delay", 32'(wait_cycles), 32'd0);   // One cycle after d_valid
        exp_instr = exp_size[0] ? {16'b0, instr[15:0]} : instr;   // 16-bit is zero-extended
        compare_field("p_rd", 32'(p_rd), 32'(exp_rd));
        compare_field("p_rs1", 32'(p_rs1), 32'(exp_rs1));
        compare_field("p_rs2", 32'(p_rs2), 32'(exp_rs2));
        compare_field("p_imm", p_imm, exp_imm);
        compare_field("p_fu", 32'(p_fu), 32'(exp_fu));
        compare_field("p_uop", 32'(p_uop), 32'(exp_uop));
        compare_field("p_trap", 32'(p_trap), 32'(exp_trap));
        compare_field("p_size", 32'(p_size), 32'(exp_size));
        compare_field("p_instr", p_instr, exp_instr);
        compare_field("p_pc", p_pc, ref_pc);
        ref_pc = ref_pc + (exp_size[0] ? 32'd2 : 32'd4);
        $display("Row %0d instr %h: %s", idx, instr, (errors == err_before) ? "ok" : "FAILED");
    endtask

    // Flush wins over an instruction offered in the same cycle
    task automatic apply_flush();
        int err_before;
        err_before = errors;
        @(posedge clk);
        flush    <= 1'b1;
        flush_pc <= FLUSH_PC;
        d_valid  <= 1'b1;
        d_data   <= 32'h00b50533;   // add x10, x10, x11
        d_error  <= 1'b0;
        @(posedge clk);
        flush   <= 1'b0;
        d_valid <= 1'b0;
        @(negedge clk);
        compare_field("p_valid", 32'(p_valid), 32'd0);
        ref_pc = FLUSH_PC;
        $display("Flush to %h: %s", FLUSH_PC, (errors == err_before) ? "ok" : "FAILED");
    endtask

    // Hold s_stall high over a valid output and watch the outputs freeze
    task automatic check_stall_hold();
        logic [124:0] snap;
        int err_before;
        err_before = errors;
        @(posedge clk);
        s_stall <= 1'b1;
        apply_row(12);
        snap = {p_valid, p_rd, p_rs1, p_rs2, p_imm, p_pc, p_instr, p_uop, p_fu, p_trap, p_size};
        repeat (3) begin
            @(negedge clk);
            compare_field("d_stall", 32'(d_stall), 32'd1);
            checks++;
            assert ({p_valid, p_rd, p_rs1, p_rs2, p_imm, p_pc, p_instr, p_uop, p_fu, p_trap,
                     p_size} === snap) else begin
                $display("MISMATCH at %0t: p_ outputs got %h expected %h", $time,
                         {p_valid, p_rd, p_rs1, p_rs2, p_imm, p_pc, p_instr, p_uop, p_fu,
                          p_trap, p_size}, snap);
                errors++;
            end
        end
        @(posedge clk);
        s_stall <= 1'b0;
        apply_row(3);   // Normal decode once the stall drops
        $display("Stall hold: %s", (errors == err_before) ? "ok" : "FAILED");
    endtask

    initial begin
        seed      = 32'haa024273;
        rst_n     = 1'b0;
        cfg_we    = 1'b0;
        cfg_wdata = 2'b11;
        d_valid   = 1'b0;
        d_data    = '0;
        d_error   = 1'b0;
        flush     = 1'b0;
        flush_pc  = '0;
        s_stall   = 1'b0;
        ref_pc    = PC_RESET;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        compare_field("p_valid", 32'(p_valid), 32'd0);
        compare_field("d_stall", 32'(d_stall), 32'd0);
        compare_field("cfg_rdata", 32'(cfg_rdata), 32'd3);
        $display("Reset state: %s", (errors == 0) ? "ok" : "FAILED");
        for (int i = 0; i < NUM_VEC; i++) begin
            if (i == FLUSH_ROW) begin
                apply_flush();
            end
            apply_row(i);
        end
        check_stall_hold();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+verilog
+incdir+verif
verilog/frv_pkg.sv
verilog/frv_core_decode.sv
verilog/frv_decode_cfg.sv
verilog/frv_pipe_decode.sv
verilog/frv_decode_top.sv
verif/tb_frv_decode.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the decode stage testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -j 0 \
    -f filelist.f --top-module tb_frv_decode \
    -Mdir obj_dir -o sim_frv_decode \
    && ./obj_dir/sim_frv_decode 2>&1 | tee sim.log \
    && grep -qx "Done: no errors" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
